// File: hw/dcache_data_array.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_macros.svh"

module dcache_data_array
    import dcache_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    rd_en,
    input  wire logic [`DC_IDX_BITS-1:0] rd_index,
    input  wire logic                    fill_en,
    input  wire logic [`DC_IDX_BITS-1:0] fill_index,
    input  wire way_t                    fill_way,
    input  wire line_t                   refill_line,
    output line_t [`DC_WAYS-1:0]         way_lines
);

    line_t rd_line [`DC_WAYS];

    // All ways of the set are read together.
    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        dcache_sram #(
            .entry_t (line_t),
            .depth   (`DC_SETS)
        ) i_line_ram (
            .clk      (clk),
            .rst      (rst),
            .rd_en    (rd_en),
            .rd_index (rd_index),
            .rd_data  (rd_line[w]),
            .wr_en    (fill_en && fill_way[w]), // Victim way only.
            .wr_index (fill_index),
            .wr_data  (refill_line)
        );

        assign way_lines[w] = rd_line[w];
    end

endmodule

`default_nettype wire

// File: hw/dcache_miss_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_macros.svh"

module dcache_miss_ctrl
    import dcache_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    req,
    input  wire logic [31:0]             addr,
    input  wire read_type_t              read_type,
    input  wire logic                    signed_ext,
    output logic                         busy,
    output logic                         rd_en,
    output logic [`DC_IDX_BITS-1:0]      rd_index,
    output logic [`DC_TAG_BITS-1:0]      cmp_tag,
    input  wire way_t                    hit_way,
    output logic                         fill_en,
    output logic [`DC_IDX_BITS-1:0]      fill_index,
    output logic [`DC_TAG_BITS-1:0]      fill_tag,
    output logic                         refill_req,
    output logic [31:0]                  refill_addr,
    input  wire logic                    refill_valid,
    output logic [31:0]                  s2_addr,
    output read_type_t                   s2_read_type,
    output logic                         s2_signed_ext,
    output logic                         data_sel,
    output logic                         rsp_load,
    output logic                         rsp_valid
);

    typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_RESPOND, ST_REPLAY} state_t;

    state_t      state;
    logic        s1_valid, s2_valid, h_valid;
    logic [31:0] s1_addr, h_addr;
    read_type_t  s1_type, h_type;
    logic        s1_sext, h_sext;
    logic        miss;
    logic        flow;

    assign miss = (state == ST_IDLE) && s2_valid && !(|hit_way);
    // Pipeline advances on a hit cycle and when the held request is replayed.
    assign flow = ((state == ST_IDLE) && !miss) || (state == ST_REPLAY);

    assign rd_en    = flow && s1_valid;
    assign rd_index = s1_addr[`DC_OFS_BITS +: `DC_IDX_BITS];
    assign cmp_tag  = s1_addr[31 -: `DC_TAG_BITS];

    assign fill_en     = (state == ST_WAIT) && refill_valid;
    assign fill_index  = s2_addr[`DC_OFS_BITS +: `DC_IDX_BITS];
    assign fill_tag    = s2_addr[31 -: `DC_TAG_BITS];
    assign refill_addr = {s2_addr[31:`DC_OFS_BITS], {`DC_OFS_BITS{1'b0}}};

    assign rsp_load = ((state == ST_IDLE) && s2_valid && !miss) || (state == ST_RESPOND);
    assign data_sel = (state != ST_RESPOND); // Refill line answers the miss.

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            h_valid    <= 1'b0;
            busy       <= 1'b0;
            refill_req <= 1'b0;
            rsp_valid  <= 1'b0;
        end else begin
            rsp_valid  <= rsp_load;
            refill_req <= miss;
            case (state)
                ST_IDLE: begin
                    if (miss) begin
                        state <= ST_WAIT;
                        busy  <= 1'b1;
                    end
                end
                ST_WAIT:    if (refill_valid) state <= ST_RESPOND;
                ST_RESPOND: state <= ST_REPLAY;
                default: begin
                    state <= ST_IDLE;
                    busy  <= 1'b0;
                end
            endcase
            if (flow) begin
                s2_valid <= s1_valid;
                s1_valid <= h_valid || req;
                h_valid  <= 1'b0;
            end else if (req) begin
                // Only in the miss cycle, behind a frozen pipeline.
                if (s1_valid) begin
                    h_valid <= 1'b1;
                end else begin
                    s1_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flow) begin
            s2_addr       <= s1_addr;
            s2_read_type  <= s1_type;
            s2_signed_ext <= s1_sext;
            s1_addr       <= h_valid ? h_addr : addr;
            s1_type       <= h_valid ? h_type : read_type;
            s1_sext       <= h_valid ? h_sext : signed_ext;
        end else if (req && s1_valid) begin
            h_addr <= addr;
            h_type <= read_type;
            h_sext <= signed_ext;
        end else if (req) begin
            s1_addr <= addr;
            s1_type <= read_type;
            s1_sext <= signed_ext;
        end
    end

endmodule

`default_nettype wire

// File: hw/dcache_pkg.sv
`default_nettype none
`include "dcache_macros.svh"

package dcache_pkg;

    // Byte-lane mask of a load.
    typedef logic [3:0] read_type_t;

    localparam read_type_t RT_BYTE = 4'b0001;
    localparam read_type_t RT_HALF = 4'b0011;
    localparam read_type_t RT_WORD = 4'b1111;

    // One-hot way select where all zero means none.
    typedef logic [`DC_WAYS-1:0] way_t;

    typedef logic [`DC_LINE_BITS-1:0] line_t;

    typedef struct packed {
        logic                    valid;
        logic [`DC_TAG_BITS-1:0] tag;
    } tag_entry_t;

endpackage

`default_nettype wire

// File: hw/dcache_rd_align.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_macros.svh"

module dcache_rd_align
    import dcache_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                rsp_load,
    input  wire logic [31:0]         addr,
    input  wire read_type_t          read_type,
    input  wire logic                signed_ext,
    input  wire way_t                hit_way,
    input  wire line_t [`DC_WAYS-1:0] way_lines,
    input  wire line_t               refill_line,
    input  wire logic                data_sel,
    output logic [31:0]              rsp_data
);

    line_t       way_data;
    logic [8:0]  word_pos;
    logic [31:0] mem_word;
    logic [31:0] bus_word;
    logic [31:0] cpu_word;
    logic [7:0]  byte_val;
    logic [15:0] half_val;
    logic [31:0] aligned;

    // Non one-hot selects give an empty line.
    always_comb begin
        way_data = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (hit_way == way_t'(1 << w)) begin
                way_data = way_lines[w];
            end
        end
    end

    assign word_pos = {addr[`DC_OFS_BITS-1:2], 5'd0};
    assign mem_word = way_data[word_pos +: 32];
    assign bus_word = refill_line[word_pos +: 32];
    assign cpu_word = data_sel ? mem_word : bus_word;

    assign byte_val = cpu_word[{addr[1:0], 3'd0} +: 8];
    assign half_val = cpu_word[{addr[1], 4'd0} +: 16];

    always_comb begin
        case (read_type)
            RT_BYTE: aligned = {{24{byte_val[7] & signed_ext}}, byte_val};
            RT_HALF: begin
                if (addr[0]) begin
                    aligned = '0; // Misaligned half.
                end else begin
                    aligned = {{16{half_val[15] & signed_ext}}, half_val};
                end
            end
            RT_WORD: aligned = cpu_word;
            default: aligned = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_data <= '0;
        end else if (rsp_load) begin
            rsp_data <= aligned;
        end
    end

endmodule

`default_nettype wire

// File: hw/dcache_sram.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_sram #(
    parameter type entry_t = logic [31:0],
    parameter int  depth   = 16
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     rd_en,
    input  wire logic [$clog2(depth)-1:0] rd_index,
    output entry_t                        rd_data,
    input  wire logic                     wr_en,
    input  wire logic [$clog2(depth)-1:0] wr_index,
    input  wire entry_t                   wr_data
);

    entry_t mem [depth];

    // Read gets the old entry on a same-index write.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
            rd_data <= '0;
        end else begin
            if (wr_en) begin
                mem[wr_index] <= wr_data;
            end
            if (rd_en) begin
                rd_data <= mem[rd_index]; // Held while idle.
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/dcache_tag_lookup.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_macros.svh"

module dcache_tag_lookup
    import dcache_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    rd_en,
    input  wire logic [`DC_IDX_BITS-1:0] rd_index,
    input  wire logic [`DC_TAG_BITS-1:0] cmp_tag,
    input  wire logic                    fill_en,
    input  wire logic [`DC_IDX_BITS-1:0] fill_index,
    input  wire logic [`DC_TAG_BITS-1:0] fill_tag,
    output way_t                         hit_way,
    output way_t                         fill_way
);

    localparam int ptr_bits = $clog2(`DC_WAYS);

    tag_entry_t              rd_entry [`DC_WAYS];
    tag_entry_t              fill_entry;
    logic [`DC_TAG_BITS-1:0] cmp_tag_q;
    logic [ptr_bits-1:0]     rr_ptr [`DC_SETS];

    assign fill_entry = '{valid: 1'b1, tag: fill_tag};

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        dcache_sram #(
            .entry_t (tag_entry_t),
            .depth   (`DC_SETS)
        ) i_tag_ram (
            .clk      (clk),
            .rst      (rst),
            .rd_en    (rd_en),
            .rd_index (rd_index),
            .rd_data  (rd_entry[w]),
            .wr_en    (fill_en && fill_way[w]),
            .wr_index (fill_index),
            .wr_data  (fill_entry)
        );
    end

    // Tag travels alongside the array read.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            cmp_tag_q <= cmp_tag;
        end
    end

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_way[w] = rd_entry[w].valid && (rd_entry[w].tag == cmp_tag_q);
        end
    end

    // Round-robin victim per set.
    assign fill_way = way_t'(1) << rr_ptr[fill_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                rr_ptr[s] <= '0;
            end
        end else if (fill_en) begin
            rr_ptr[fill_index] <= rr_ptr[fill_index] + 1'b1; // Wraps after the last way.
        end
    end

endmodule

`default_nettype wire

// File: hw/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_macros.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        req,
    input  wire logic [31:0] addr,
    input  wire read_type_t  read_type,
    input  wire logic        signed_ext,
    output logic             busy,
    output logic             rsp_valid,
    output logic [31:0]      rsp_data,
    output logic             refill_req,
    output logic [31:0]      refill_addr,
    input  wire logic        refill_valid,
    input  wire line_t       refill_line
);

    logic                    rd_en;
    logic [`DC_IDX_BITS-1:0] rd_index;
    logic [`DC_TAG_BITS-1:0] cmp_tag;
    logic                    fill_en;
    logic [`DC_IDX_BITS-1:0] fill_index;
    logic [`DC_TAG_BITS-1:0] fill_tag;
    way_t                    hit_way;
    way_t                    fill_way;
    line_t [`DC_WAYS-1:0]    way_lines;
    logic [31:0]             s2_addr;
    read_type_t              s2_read_type;
    logic                    s2_signed_ext;
    logic                    data_sel;
    logic                    rsp_load;

    dcache_miss_ctrl i_miss_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .addr          (addr),
        .read_type     (read_type),
        .signed_ext    (signed_ext),
        .busy          (busy),
        .rd_en         (rd_en),
        .rd_index      (rd_index),
        .cmp_tag       (cmp_tag),
        .hit_way       (hit_way),
        .fill_en       (fill_en),
        .fill_index    (fill_index),
        .fill_tag      (fill_tag),
        .refill_req    (refill_req),
        .refill_addr   (refill_addr),
        .refill_valid  (refill_valid),
        .s2_addr       (s2_addr),
        .s2_read_type  (s2_read_type),
        .s2_signed_ext (s2_signed_ext),
        .data_sel      (data_sel),
        .rsp_load      (rsp_load),
        .rsp_valid     (rsp_valid)
    );

    // Tags and lines are read side by side.
    dcache_tag_lookup i_tag_lookup (
        .clk        (clk),
        .rst        (rst),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .cmp_tag    (cmp_tag),
        .fill_en    (fill_en),
        .fill_index (fill_index),
        .fill_tag   (fill_tag),
        .hit_way    (hit_way),
        .fill_way   (fill_way)
    );

    dcache_data_array i_data_array (
        .clk         (clk),
        .rst         (rst),
        .rd_en       (rd_en),
        .rd_index    (rd_index),
        .fill_en     (fill_en),
        .fill_index  (fill_index),
        .fill_way    (fill_way),
        .refill_line (refill_line),
        .way_lines   (way_lines)
    );

    dcache_rd_align i_rd_align (
        .clk         (clk),
        .rst         (rst),
        .rsp_load    (rsp_load),
        .addr        (s2_addr),
        .read_type   (s2_read_type),
        .signed_ext  (s2_signed_ext),
        .hit_way     (hit_way),
        .way_lines   (way_lines),
        .refill_line (refill_line),
        .data_sel    (data_sel),
        .rsp_data    (rsp_data)
    );

endmodule

`default_nettype wire

// File: include/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Cache geometry.
`define DC_WAYS      4
`define DC_SETS      16
`define DC_LINE_BITS 512

// Address split as tag | index | offset.
`define DC_TAG_BITS  22
`define DC_IDX_BITS  4
`define DC_OFS_BITS  6

`endif

// File: src.f
+incdir+include
hw/dcache_pkg.sv
hw/dcache_sram.sv
hw/dcache_tag_lookup.sv
hw/dcache_data_array.sv
hw/dcache_rd_align.sv
hw/dcache_miss_ctrl.sv
hw/dcache_top.sv
tests/dcache_chk.sv
tests/tb_dcache_top.sv

// File: tests/dcache_chk.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_chk (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic        req,
    input wire logic        busy,
    input wire logic        rsp_valid,
    input wire logic        refill_req,
    input wire logic        refill_valid,
    input wire logic [31:0] refill_addr
);

    int unsigned fail_count = 0;
    logic        refill_open;

    // Set from refill request until the line comes back.
    always_ff @(posedge clk) begin
        if (rst) begin
            refill_open <= 1'b0;
        end else if (refill_req) begin
            refill_open <= 1'b1;
        end else if (refill_valid) begin
            refill_open <= 1'b0;
        end
    end

    no_req_while_busy: assert property (@(posedge clk) disable iff (rst) busy |-> !req)
        else begin
            fail_count++;
            $error("req driven while busy");
        end

    refill_answered: assert property (@(posedge clk) disable iff (rst)
        refill_valid |-> ##2 rsp_valid)
        else begin
            fail_count++;
            $error("missed load not answered right after its refill");
        end

    one_refill_open: assert property (@(posedge clk) disable iff (rst)
        refill_req |-> !refill_open)
        else begin
            fail_count++;
            $error("refill_req while a refill is outstanding");
        end

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> (!rsp_valid && !refill_req && !busy))
        else begin
            fail_count++;
            $error("outputs active after reset");
        end

endmodule

bind dcache_top dcache_chk i_chk (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .busy         (busy),
    .rsp_valid    (rsp_valid),
    .refill_req   (refill_req),
    .refill_valid (refill_valid),
    .refill_addr  (refill_addr)
);

`default_nettype wire

// File: tests/tb_dcache_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_macros.svh"

module tb_dcache_top
    import dcache_pkg::*;
();

    logic        clk;
    logic        rst;
    logic        req;
    logic [31:0] addr;
    read_type_t  read_type;
    logic        signed_ext;
    logic        busy;
    logic        rsp_valid;
    logic [31:0] rsp_data;
    logic        refill_req;
    logic [31:0] refill_addr;
    logic        refill_valid;
    line_t       refill_line;

    // Reference model of tags and round-robin pointers.
    logic                    tag_valid [`DC_SETS][`DC_WAYS];
    logic [`DC_TAG_BITS-1:0] tag_store [`DC_SETS][`DC_WAYS];
    int                      rr_next [`DC_SETS];

    logic [31:0] want_data_q [$];
    int          want_cycle_q [$]; // -1 when latency is not fixed.
    bit          want_miss_q [$];
    logic [31:0] refill_q [$];

    integer seed = 32'h257c_7a67;
    int     cycle = 0;
    int     issued = 0;

    dcache_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .addr         (addr),
        .read_type    (read_type),
        .signed_ext   (signed_ext),
        .busy         (busy),
        .rsp_valid    (rsp_valid),
        .rsp_data     (rsp_data),
        .refill_req   (refill_req),
        .refill_addr  (refill_addr),
        .refill_valid (refill_valid),
        .refill_line  (refill_line)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, want);
            $display("*** FAILED ***");
            $fatal(1, "%s check failed", name);
        end
    endtask

    // Memory content is a scramble of the word address.
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] w;
        w = a * 32'h9e37_79b9;
        return w ^ (w >> 15) ^ {a[9:2], 24'h5a_c3e1};
    endfunction

    function automatic line_t build_line(input logic [31:0] line_addr);
        line_t line;
        for (int i = 0; i < 16; i++) begin
            line[i*32 +: 32] = mem_word(line_addr + 4 * i);
        end
        return line;
    endfunction

    function automatic logic [31:0] expected_load(input logic [31:0] a, input read_type_t rt,
                                                  input logic sx);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = mem_word({a[31:2], 2'b00});
        b = w >> (8 * a[1:0]); // Little-endian lanes.
        h = w >> (16 * a[1]);
        case (rt)
            RT_BYTE: return sx ? {{24{b[7]}}, b} : {24'h0, b};
            RT_HALF: begin
                if (a[0]) begin
                    return 32'h0;
                end
                return sx ? {{16{h[15]}}, h} : {16'h0, h};
            end
            RT_WORD: return w;
            default: return 32'h0;
        endcase
    endfunction

    // Returns hit, and on a miss fills the victim way like the cache.
    function automatic bit lookup_model(input logic [31:0] a);
        int                      s;
        logic [`DC_TAG_BITS-1:0] t;
        s = a[`DC_OFS_BITS +: `DC_IDX_BITS];
        t = a[31 -: `DC_TAG_BITS];
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (tag_valid[s][w] && tag_store[s][w] == t) begin
                return 1'b1;
            end
        end
        tag_valid[s][rr_next[s]] = 1'b1;
        tag_store[s][rr_next[s]] = t;
        rr_next[s] = (rr_next[s] + 1) % `DC_WAYS;
        return 1'b0;
    endfunction

    task automatic issue_load(input logic [31:0] a, input read_type_t rt, input logic sx);
        bit hit;
        bit miss_pending;
        while (busy) begin
            @(posedge clk);
            #1;
        end
        miss_pending = 1'b0;
        foreach (want_miss_q[i]) begin
            miss_pending |= want_miss_q[i];
        end
        hit = lookup_model(a);
        if (!hit) begin
            refill_q.push_back({a[31:`DC_OFS_BITS], 6'd0});
        end
        want_data_q.push_back(expected_load(a, rt, sx));
        want_cycle_q.push_back((hit && !miss_pending) ? cycle + 3 : -1);
        want_miss_q.push_back(!hit);
        issued++;
        req        = 1'b1;
        addr       = a;
        read_type  = rt;
        signed_ext = sx;
        @(posedge clk);
        #1;
        req = 1'b0;
    endtask

    task automatic drain();
        while (want_data_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        if (refill_q.size() != 0) begin
            report_failure("an expected refill request never came");
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > 40 * issued + 200) begin
            report_failure("timeout, the cache stopped answering");
        end
    end

    always @(negedge clk) begin : compare
        logic [31:0] want;
        int          when;
        if (!rst && i_dut.i_chk.fail_count != 0) begin
            report_failure("a protocol assertion fired");
        end else if (!rst && rsp_valid) begin
            if (want_data_q.size() == 0) begin
                report_failure("response with no load outstanding");
            end else begin
                want = want_data_q.pop_front();
                when = want_cycle_q.pop_front();
                void'(want_miss_q.pop_front());
                check_value("rsp_data", rsp_data, want);
                if (when >= 0) begin
                    check_value("rsp_valid cycle", cycle, when);
                end
            end
        end
    end

    // Memory answers each refill after 1 to 8 cycles.
    initial begin : memory_model
        int          delay;
        logic [31:0] line_addr;
        refill_valid = 1'b0;
        refill_line  = '0;
        forever begin
            @(negedge clk);
            if (!rst && refill_req) begin
                if (refill_q.size() == 0) begin
                    report_failure("unexpected refill request");
                end else begin
                    line_addr = refill_q.pop_front();
                    check_value("refill_addr", refill_addr, line_addr);
                    check_value("busy", busy, 32'd1);
                    delay = 1 + ($unsigned($random(seed)) % 8);
                    repeat (delay) @(posedge clk);
                    #1;
                    refill_line  = build_line(line_addr); // Held for the response cycle.
                    refill_valid = 1'b1;
                    @(posedge clk);
                    #1;
                    refill_valid = 1'b0;
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] base;
        logic [31:0] a;
        read_type_t  rt;
        rst        = 1'b1;
        req        = 1'b0;
        addr       = '0;
        read_type  = RT_WORD;
        signed_ext = 1'b0;
        for (int s = 0; s < `DC_SETS; s++) begin
            rr_next[s] = 0;
            for (int w = 0; w < `DC_WAYS; w++) begin
                tag_valid[s][w] = 1'b0;
                tag_store[s][w] = '0;
            end
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // First touch at an unaligned address, then every offset and type.
        base = 32'h0000_1000;
        issue_load(base + 32'h37, RT_BYTE, 1'b1);
        for (int ofs = 0; ofs < 64; ofs++) begin
            for (int sx = 0; sx < 2; sx++) begin
                issue_load(base + ofs, RT_BYTE, sx[0]);
                issue_load(base + ofs, RT_HALF, sx[0]);
            end
            if (ofs % 4 == 0) begin
                issue_load(base + ofs, RT_WORD, 1'b0);
            end
        end
        issue_load(base + 8, 4'b0000, 1'b1); // Undefined types.
        issue_load(base + 12, 4'b0111, 1'b0);
        issue_load(base + 16, 4'b1000, 1'b1);
        drain();

        for (int i = 0; i < 12; i++) begin
            issue_load(base + 4 * i, RT_WORD, 1'b0);
        end
        drain();

        // Five lines in set 5 where the fifth evicts the first.
        for (int i = 0; i < 5; i++) begin
            issue_load({22'h100 + 22'(i), 4'd5, 6'h10}, RT_WORD, 1'b0);
        end
        drain();
        issue_load({22'h100, 4'd5, 6'h04}, RT_HALF, 1'b1);
        issue_load({22'h102, 4'd5, 6'h08}, RT_WORD, 1'b0);
        drain();

        // Requests right behind a miss.
        issue_load(32'h0008_0044, RT_WORD, 1'b0);
        issue_load(32'h0008_0046, RT_HALF, 1'b1);
        issue_load(base + 32'h21, RT_BYTE, 1'b1);
        drain();
        issue_load(32'h000c_0080, RT_BYTE, 1'b0);
        issue_load(32'h000d_0083, RT_BYTE, 1'b1);
        drain();

        for (int i = 0; i < 80; i++) begin
            a[31:10] = 22'h200 + 22'($unsigned($random(seed)) % 6);
            a[9:6]   = 4'($unsigned($random(seed)) % 3);
            a[5:0]   = 6'($random(seed));
            case ($unsigned($random(seed)) % 4)
                0: rt = RT_BYTE;
                1: rt = RT_HALF;
                2: rt = RT_WORD;
                default: rt = 4'b0101;
            endcase
            issue_load(a, rt, 1'($random(seed)));
            repeat ($unsigned($random(seed)) % 3) begin
                @(posedge clk);
                #1;
            end
        end
        drain();

        repeat (4) begin
            @(posedge clk);
            #1;
        end
        if (busy) begin
            report_failure("cache still busy after the last response");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire
